/* dv/uplink_stim.txt */
# op name f0..f5 in hex; write: addr data, read: addr expected
# send: mask word0 word1 word2 word3 random_flag, block: mask
read  ctrl_reset    0 f    0    0    0    0
read  div_reset     4 1b1  0    0    0    0
write ctrl_write    0 5    0    0    0    0
read  ctrl_readback 0 5    0    0    0    0
write div_write     4 7    0    0    0    0
read  div_readback  4 7    0    0    0    0
read  undef_offset  6 0    0    0    0    0
write ctrl_all_on   0 f    0    0    0    0
send  single_ch2    4 0    0    a55a 0    0
send  prio_ch1_ch3  a 0    1c3e 0    7d40 0
write ctrl_ch0_off  0 e    0    0    0    0
block ch0_masked    1 0    0    0    0    0
write ctrl_ch0_on   0 f    0    0    0    0
send  ch0_enabled   1 beef 0    0    0    0
read  frames_before c 4    0    0    0    0
send  backpressure  f 0    0    0    0    1
read  frames_after  c 8    0    0    0    0
read  status_idle   8 0    0    0    0    0

/* uplink_top.f */
hw/uplink_pkg.sv
hw/byte_fifo.sv
hw/frame_mux.sv
hw/uart_tx.sv
hw/uplink_regs.sv
hw/uplink_top.sv
dv/uplink_tb.sv

/* run.sh */
#!/bin/sh
# build the uplink testbench with Verilator, run it, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module uplink_tb -f uplink_top.f -o uplink_sim \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/uplink_sim > sim.log 2>&1 ; cat sim.log
! grep -q "ERRORS FOUND" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* dv/uplink_tb.sv */
`timescale 1ns/1ps

module uplink_tb;

   logic                                             clk;
   logic                                             rst_n;
   uplink_pkg::chan_req_t [uplink_pkg::num_chan-1:0] src;
   logic [uplink_pkg::num_chan-1:0]                  accept;
   uplink_pkg::apb_req_t                             apb;
   logic [31:0]                                      prdata;
   logic                                             txd;

   string            ops[$];
   string            names[$];
   logic [5:0][15:0] args[$];     // up to six hex fields per vector
   logic [7:0]       rx_q[$];     // bytes decoded from txd
   logic [15:0]      div_val;     // bit period the decoder assumes
   integer           seed;
   int               errors;
   int               tests;
   int               failed;
   int               cycles = 0;
   int               limit = 0;

   uplink_top dut0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .src    (src),
      .accept (accept),
      .apb    (apb),
      .prdata (prdata),
      .txd    (txd)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: run stopped after %0d cycles without finishing", cycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      @(negedge clk);
      apb.psel    = 1'b1;   // setup phase
      apb.penable = 1'b0;
      apb.pwrite  = wr;
      apb.paddr   = addr;
      apb.pwdata  = wdata;
      @(negedge clk);
      apb.penable = 1'b1;
      #5 rdata = prdata;    // mid access phase
      @(negedge clk);
      apb.psel    = 1'b0;
      apb.penable = 1'b0;
      apb.pwrite  = 1'b0;
   endtask

   // 8N1 receiver sampling each bit in its middle
   initial begin : serial_rx
      logic [7:0] b;
      wait (rst_n === 1'b1);
      forever begin
         @(negedge txd);
         repeat ((div_val + 1) / 2) @(negedge clk);
         for (int i = 0; i < 8; i++) begin
            repeat (div_val + 1) @(negedge clk);
            b[i] = txd;   // lsb first
         end
         repeat (div_val + 1) @(negedge clk);
         if (txd !== 1'b1) begin
            $display("framing error: stop bit on txd was low");
            errors++;
         end
         rx_q.push_back(b);
      end
   end

   task automatic send_frames(input string name, input logic [3:0] mask,
                              input logic [3:0][15:0] words);
      logic [7:0] exp_q[$];
      logic [3:0] seen;
      logic [3:0] done;
      int         n;
      @(negedge clk);
      for (int i = 0; i < 4; i++) begin
         src[i].req  = mask[i];
         src[i].data = words[i];
         if (mask[i]) begin   // lowest index goes first
            exp_q.push_back(8'(i));
            exp_q.push_back(words[i][15:8]);
            exp_q.push_back(words[i][7:0]);
         end
      end
      seen = '0;
      done = ~mask;
      while (done != 4'hF) begin
         @(negedge clk);
         for (int i = 0; i < 4; i++) begin
            if (accept[i]) seen[i] = 1'b1;
            if (seen[i] && !accept[i] && !done[i]) begin
               done[i]    = 1'b1;
               src[i].req = 1'b0;   // accept rose and fell
            end
         end
      end
      while (rx_q.size() < exp_q.size()) @(negedge clk);
      repeat (div_val + 1) @(negedge clk);   // let the last stop bit end
      n = exp_q.size();
      for (int k = 0; k < n; k++) check(name, exp_q[k], rx_q.pop_front());
   endtask

   task automatic hold_off(input string name, input logic [3:0] mask);
      logic [3:0] got;
      got = '0;
      @(negedge clk);
      for (int i = 0; i < 4; i++) src[i].req = mask[i];
      repeat (100) begin
         @(negedge clk);
         got = got | (accept & mask);
      end
      check(name, 32'd0, {28'd0, got});
      src = '0;
   endtask

   initial begin : main
      int               fd;
      int               frames;
      int               div_last;
      int               err_before;
      string            line;
      string            op;
      string            name;
      logic [15:0]      f0, f1, f2, f3, f4, f5;
      logic [31:0]      rd;
      logic [5:0][15:0] v;
      logic [3:0][15:0] words;
      seed     = 32'h0a9f_2cc6;
      errors   = 0;
      tests    = 0;
      failed   = 0;
      frames   = 0;
      div_last = 433;
      div_val  = 16'd433;   // divisor after reset
      rst_n    = 1'b0;
      apb      = '0;
      src      = '0;
      fd = $fopen("dv/uplink_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open dv/uplink_stim.txt");
         errors++;
      end else begin
         while ($fgets(line, fd) > 0) begin
            if (line.len() < 3 || line.substr(0, 0) == "#") continue;
            if ($sscanf(line, "%s %s %h %h %h %h %h %h",
                        op, name, f0, f1, f2, f3, f4, f5) != 8) begin
               $display("stim line could not be parsed: %s", line);
               errors++;
               continue;
            end
            ops.push_back(op);
            names.push_back(name);
            args.push_back({f5, f4, f3, f2, f1, f0});
            if (op == "write" && f0 == 16'h4) div_last = int'(f1);
            if (op == "send") frames += $countones(f0[3:0]);
         end
         $fclose(fd);
      end
      limit = frames * 30 * (div_last + 1) + 2000;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      foreach (ops[t]) begin
         v          = args[t];
         err_before = errors;
         if (ops[t] == "write") begin
            apb_access(1'b1, v[0][3:0], {16'd0, v[1]}, rd);
            if (v[0][3:0] == 4'h4) div_val = v[1];
         end else if (ops[t] == "read") begin
            apb_access(1'b0, v[0][3:0], 32'd0, rd);
            check(names[t], {16'd0, v[1]}, rd);
         end else if (ops[t] == "send") begin
            for (int i = 0; i < 4; i++) words[i] = v[5][0] ? 16'($random(seed)) : v[i+1];
            send_frames(names[t], v[0][3:0], words);
         end else if (ops[t] == "block") begin
            hold_off(names[t], v[0][3:0]);
         end else begin
            $display("unknown operation %s in test %s", ops[t], names[t]);
            errors++;
         end
         tests++;
         if (errors != err_before) failed++;
         $display("test %-16s %s", names[t], (errors == err_before) ? "passed" : "failed");
      end
      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* hw/uplink_top.sv */
`timescale 1ns/1ps

module uplink_top (
   input  logic                                           clk,
   input  logic                                           rst_n,
   input  uplink_pkg::chan_req_t [uplink_pkg::num_chan-1:0] src,
   output logic [uplink_pkg::num_chan-1:0]                accept,
   input  uplink_pkg::apb_req_t                           apb,
   output logic [31:0]                                    prdata,
   output logic                                           txd
);

   uplink_pkg::uplink_cfg_t  cfg;
   uplink_pkg::uplink_stat_t stat;

   logic [7:0] wdata;
   logic       winc;
   logic       full;
   logic [7:0] rdata;
   logic       empty;
   logic       rinc;

   uplink_regs regs0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .apb    (apb),
      .stat   (stat),
      .prdata (prdata),
      .cfg    (cfg)
   );

   frame_mux mux0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .src        (src),
      .en_mask    (cfg.en_mask),
      .full       (full),
      .accept     (accept),
      .wdata      (wdata),
      .winc       (winc),
      .frame_done (stat.frame_done)
   );

   byte_fifo #(.depth(uplink_pkg::fifo_depth)) fifo0 (
      .clk   (clk),
      .rst_n (rst_n),
      .wdata (wdata),
      .winc  (winc),
      .rinc  (rinc),
      .rdata (rdata),
      .full  (full),
      .empty (empty),
      .level (stat.fifo_level)
   );

   uart_tx uart0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .divisor (cfg.divisor),
      .rdata   (rdata),
      .empty   (empty),
      .rinc    (rinc),
      .txd     (txd),
      .busy    (stat.uart_busy)
   );

endmodule

/* hw/uplink_regs.sv */
`timescale 1ns/1ps

module uplink_regs (
   input  logic                     clk,
   input  logic                     rst_n,
   input  uplink_pkg::apb_req_t     apb,
   input  uplink_pkg::uplink_stat_t stat,
   output logic [31:0]              prdata,
   output uplink_pkg::uplink_cfg_t  cfg
);

   logic [uplink_pkg::num_chan-1:0] ctrl_q;
   logic [uplink_pkg::div_w-1:0]    div_q;
   logic [15:0]                     frames_q;
   logic                            wr_en;
   logic                            rd_en;

   assign wr_en = apb.psel & apb.penable & apb.pwrite;   // access phase
   assign rd_en = apb.psel & apb.penable & ~apb.pwrite;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl_q   <= '1;   // all channels on
         div_q    <= uplink_pkg::div_reset;
         frames_q <= '0;
      end else begin
         if (wr_en && apb.paddr == uplink_pkg::reg_ctrl) begin
            ctrl_q <= apb.pwdata[3:0];
         end
         if (wr_en && apb.paddr == uplink_pkg::reg_div) begin
            div_q <= apb.pwdata[15:0];
         end
         if (stat.frame_done) frames_q <= frames_q + 16'd1;   // wraps
      end
   end

   // status is read live from the datapath
   always_comb begin
      prdata = 32'd0;
      if (rd_en) begin
         case (apb.paddr)
            uplink_pkg::reg_ctrl:   prdata = {28'd0, ctrl_q};
            uplink_pkg::reg_div:    prdata = {16'd0, div_q};
            uplink_pkg::reg_status: prdata = {27'd0, stat.uart_busy, stat.fifo_level};
            uplink_pkg::reg_frames: prdata = {16'd0, frames_q};
            default:                prdata = 32'd0;   // undefined offset
         endcase
      end
   end

   assign cfg.en_mask = ctrl_q;
   assign cfg.divisor = div_q;

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [uplink_pkg::div_w-1:0] divisor,
   input  logic [7:0]                   rdata,
   input  logic                         empty,
   output logic                         rinc,
   output logic                         txd,
   output logic                         busy
);

   logic                         active;
   logic [uplink_pkg::div_w-1:0] cnt;      // cycles within a bit
   logic [3:0]                   bit_idx;  // 0 start, 1..8 data, 9 stop
   logic [9:0]                   shreg;    // {stop, data, start}
   logic                         bit_end;
   logic                         last_bit;

   assign bit_end  = active && (cnt == divisor);
   assign last_bit = bit_end && (bit_idx == 4'd9);

   // pull the next byte when idle or when the stop bit ends
   assign rinc = (~active | last_bit) & ~empty;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active  <= 1'b0;
         cnt     <= '0;
         bit_idx <= 4'd0;
         shreg   <= '1;   // line idles high
      end else if (rinc) begin
         active  <= 1'b1;
         cnt     <= '0;
         bit_idx <= 4'd0;
         shreg   <= {1'b1, rdata, 1'b0};
      end else if (last_bit) begin
         active  <= 1'b0;
         cnt     <= '0;
         shreg   <= {1'b1, shreg[9:1]};
      end else if (bit_end) begin
         cnt     <= '0;
         bit_idx <= bit_idx + 4'd1;
         shreg   <= {1'b1, shreg[9:1]};   // lsb first
      end else if (active) begin
         cnt     <= cnt + 1'b1;
      end
   end

   assign txd  = shreg[0];
   assign busy = active;

endmodule

/* hw/frame_mux.sv */
`timescale 1ns/1ps

module frame_mux (
   input  logic                                           clk,
   input  logic                                           rst_n,
   input  uplink_pkg::chan_req_t [uplink_pkg::num_chan-1:0] src,
   input  logic [uplink_pkg::num_chan-1:0]                en_mask,
   input  logic                                           full,
   output logic [uplink_pkg::num_chan-1:0]                accept,
   output logic [7:0]                                     wdata,
   output logic                                           winc,
   output logic                                           frame_done
);

   typedef enum logic [2:0] {
      st_idle      = 3'b000,
      st_hdr_setup = 3'b001,
      st_hdr_send  = 3'b011,
      st_msb_setup = 3'b010,
      st_msb_send  = 3'b110,
      st_lsb_setup = 3'b100,
      st_lsb_send  = 3'b101,
      st_finish    = 3'b111
   } state_t;

   state_t      state;
   logic [1:0]  sel;       // channel of the current frame
   logic [15:0] word;      // word captured at frame start
   logic        hit;
   logic [1:0]  pick;

   // lowest enabled requester wins
   always_comb begin
      hit  = 1'b0;
      pick = 2'd0;
      for (int i = uplink_pkg::num_chan - 1; i >= 0; i--) begin
         if (src[i].req && en_mask[i]) begin
            hit  = 1'b1;
            pick = i[1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:      if (hit) state <= st_hdr_setup;
            st_hdr_setup: if (!full) state <= st_hdr_send;
            st_hdr_send:  state <= st_msb_setup;
            st_msb_setup: if (!full) state <= st_msb_send;
            st_msb_send:  state <= st_lsb_setup;
            st_lsb_setup: if (!full) state <= st_lsb_send;
            st_lsb_send:  state <= st_finish;
            default:      state <= st_idle;   // finish
         endcase
      end
   end

   // frame payload loaded only when leaving idle
   always_ff @(posedge clk) begin
      if (state == st_idle && hit) begin
         sel  <= pick;
         word <= src[pick].data;
      end
   end

   always_comb begin
      wdata  = 8'h00;
      winc   = 1'b0;
      accept = '0;
      if (state != st_idle) accept[sel] = 1'b1;   // held through finish
      case (state)
         st_hdr_setup, st_hdr_send: wdata = {6'd0, sel};
         st_msb_setup, st_msb_send: wdata = word[15:8];
         st_lsb_setup, st_lsb_send: wdata = word[7:0];
         default:                   wdata = 8'h00;
      endcase
      if (state == st_hdr_send || state == st_msb_send || state == st_lsb_send) begin
         winc = 1'b1;   // full was low in the setup cycle
      end
   end

   assign frame_done = (state == st_finish);

endmodule

/* hw/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo #(
   parameter int depth = 8
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [7:0]                          wdata,
   input  logic                                winc,
   input  logic                                rinc,
   output logic [7:0]                          rdata,
   output logic                                full,
   output logic                                empty,
   output logic [uplink_pkg::fifo_level_w-1:0] level
);

   localparam int aw = $clog2(depth);

   logic [7:0] mem [depth];
   logic [aw:0] wptr;   // extra msb tells full from empty
   logic [aw:0] rptr;
   logic        do_wr;
   logic        do_rd;

   assign do_wr = winc & ~full;   // writes while full are dropped
   assign do_rd = rinc & ~empty;

   always_ff @(posedge clk) begin
      if (do_wr) mem[wptr[aw-1:0]] <= wdata;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wptr <= '0;
         rptr <= '0;
      end else begin
         if (do_wr) wptr <= wptr + 1'b1;
         if (do_rd) rptr <= rptr + 1'b1;
      end
   end

   assign rdata = mem[rptr[aw-1:0]];   // head entry shown without a read
   assign empty = (wptr == rptr);
   assign full  = (wptr[aw] != rptr[aw]) && (wptr[aw-1:0] == rptr[aw-1:0]);
   assign level = wptr - rptr;

endmodule

/* hw/uplink_pkg.sv */
package uplink_pkg;

   localparam int num_chan     = 4;
   localparam int fifo_depth   = 8;
   localparam int fifo_level_w = 4;    // holds 0..fifo_depth
   localparam int div_w        = 16;

   localparam logic [div_w-1:0] div_reset = 16'd433;

   // apb register offsets
   localparam logic [3:0] reg_ctrl   = 4'h0;  // [3:0] enable mask
   localparam logic [3:0] reg_div    = 4'h4;  // [15:0] bit period - 1
   localparam logic [3:0] reg_status = 4'h8;  // [3:0] fifo level, [4] uart busy
   localparam logic [3:0] reg_frames = 4'hC;  // [15:0] sent frames

   // one telemetry source
   typedef struct packed {
      logic        req;
      logic [15:0] data;
   } chan_req_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [3:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   // register block to datapath
   typedef struct packed {
      logic [num_chan-1:0] en_mask;
      logic [div_w-1:0]    divisor;
   } uplink_cfg_t;

   // datapath back to register block
   typedef struct packed {
      logic [fifo_level_w-1:0] fifo_level;
      logic                    uart_busy;
      logic                    frame_done;  // one cycle per frame
   } uplink_stat_t;

endpackage
